//--- tests/bp_testdata.txt
# rep q_valid q_kind q_pc q_is_eq q_imm_neg q_pc_next r_valid r_pc r_is_eq r_imm_neg r_taken
# exp_taken exp_target_valid exp_target   (kind: 0 none, 1 branch, 2 call, 3 ret)
1 1 1 00000100 0 1 00000104 0 00000000 0 0 0 0 0 00000000
1 0 0 00000000 0 0 00000000 1 00000300 0 1 1 0 0 00000000
1 1 1 00000100 0 1 00000104 0 00000000 0 0 0 1 0 00000000
1 1 1 00000200 0 0 00000204 0 00000000 0 0 0 0 0 00000000
5 0 0 00000000 0 0 00000000 1 00000004 1 0 1 0 0 00000000
1 1 1 00000004 1 0 00000008 1 00000004 1 0 1 0 0 00000000
2 0 0 00000000 0 0 00000000 1 00000004 1 0 1 0 0 00000000
1 1 1 00000004 1 0 00000008 0 00000000 0 0 0 1 0 00000000
1 1 1 00000004 0 0 00000008 0 00000000 0 0 0 0 0 00000000
1 1 1 00000100 0 0 00000104 1 00000100 0 0 1 0 0 00000000
3 0 0 00000000 0 0 00000000 1 00000100 0 0 1 0 0 00000000
1 1 1 00000100 0 0 00000104 0 00000000 0 0 0 1 0 00000000
1 0 0 00000000 0 0 00000000 1 00000008 0 1 1 0 0 00000000
1 0 0 00000000 0 0 00000000 1 0000000c 0 1 1 0 0 00000000
1 0 0 00000000 0 0 00000000 1 00000010 0 1 1 0 0 00000000
59 0 0 00000000 0 0 00000000 1 00000100 0 1 1 0 0 00000000
1 1 1 00000100 0 0 00000104 1 00000100 0 1 1 0 0 00000000
1 1 1 00000100 0 0 00000104 0 00000000 0 0 0 1 0 00000000
1 1 2 00001000 0 0 00001004 0 00000000 0 0 0 1 0 00000000
1 1 2 00002000 0 0 00002004 0 00000000 0 0 0 1 0 00000000
1 1 2 00003000 0 0 00003004 0 00000000 0 0 0 1 0 00000000
1 1 2 00004000 0 0 00004004 0 00000000 0 0 0 1 0 00000000
1 1 2 00005000 0 0 00005004 0 00000000 0 0 0 1 0 00000000
1 1 2 00006000 0 0 00006004 0 00000000 0 0 0 1 0 00000000
1 1 2 00007000 0 0 00007004 0 00000000 0 0 0 1 0 00000000
1 1 2 00008000 0 0 00008004 0 00000000 0 0 0 1 0 00000000
1 1 2 00009000 0 0 00009004 0 00000000 0 0 0 1 0 00000000
1 1 3 0000a000 0 0 0000a004 0 00000000 0 0 0 1 1 00009004
1 1 3 0000a000 0 0 0000a004 0 00000000 0 0 0 1 1 00008004
1 1 3 0000a000 0 0 0000a004 0 00000000 0 0 0 1 1 00007004
1 1 3 0000a000 0 0 0000a004 0 00000000 0 0 0 1 1 00006004
1 1 3 0000a000 0 0 0000a004 0 00000000 0 0 0 1 1 00005004
1 1 3 0000a000 0 0 0000a004 0 00000000 0 0 0 1 1 00004004
1 1 3 0000a000 0 0 0000a004 0 00000000 0 0 0 1 1 00003004
1 1 3 0000a000 0 0 0000a004 0 00000000 0 0 0 1 1 00002004
1 1 3 0000a000 0 0 0000a004 0 00000000 0 0 0 1 0 00000000
1 0 0 00000000 0 0 00000000 0 00000000 0 0 0 0 0 00000000

//--- vlog.f
design/bp_pkg.sv
design/history_predictor.sv
design/meta_predictor.sv
design/return_address_stack.sv
design/branch_predictor.sv
tests/bp_props.sv
tests/bp_checker.sv
tests/tb_branch_predictor.sv

//--- run.sh
#!/bin/sh
# Build and run the branch predictor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f \
	--top-module tb_branch_predictor -o sim_tb_branch_predictor

./obj_dir/sim_tb_branch_predictor > sim.log
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"

//--- tests/tb_branch_predictor.sv
`timescale 1ns/1ns
`default_nettype none

module tb_branch_predictor import bp_pkg::*; ();

	localparam int max_cycles = 2000;

	logic           clk;
	logic           arst_n;
	bp_query_t      query;
	bp_resolve_t    resolve;
	bp_prediction_t prediction;
	bp_prediction_t expected;
	logic           check_en;

	int          err_count;
	int          check_count;
	int          file_errors;
	int          cycles;
	bit          timed_out;
	logic [31:0] col [15];

	branch_predictor dut (
		.clk(clk),
		.arst_n(arst_n),
		.query(query),
		.resolve(resolve),
		.prediction(prediction)
	);

	bp_checker pred_check (
		.clk(clk),
		.arst_n(arst_n),
		.check_en(check_en),
		.expected(expected),
		.prediction(prediction),
		.err_count(err_count),
		.check_count(check_count)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Columns 1 to 14 of a data row
	task automatic drive_row();
		query.valid      = col[1][0];
		query.kind       = br_kind_t'(col[2][1:0]);
		query.pc         = col[3];
		query.is_eq      = col[4][0];
		query.imm_neg    = col[5][0];
		query.pc_next    = col[6];
		resolve.valid    = col[7][0];
		resolve.pc       = col[8];
		resolve.is_eq    = col[9][0];
		resolve.imm_neg  = col[10][0];
		resolve.taken    = col[11][0];
		expected.taken        = col[12][0];
		expected.target_valid = col[13][0];
		expected.target       = col[14];
	endtask

	initial begin
		int    fd;
		int    n;
		int    line_no;
		int    k;
		bit    done;
		string line;

		arst_n      = 1'b0;
		query       = '0;
		resolve     = '0;
		expected    = '0;
		check_en    = 1'b0;
		file_errors = 0;
		cycles      = 0;
		timed_out   = 1'b0;
		done        = 1'b0;
		line_no     = 0;

		repeat (5) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		fd = $fopen("tests/bp_testdata.txt", "r");
		if (fd == 0) begin
			$display("Could not open the test data file tests/bp_testdata.txt");
			file_errors++;
			done = 1'b1;
		end

		while (!done && !timed_out) begin
			line_no++;
			if ($fgets(line, fd) == 0) begin
				done = 1'b1;
			end else if (line.len() > 1 && line.getc(0) != "#") begin
				n = $sscanf(line, "%d %d %d %h %d %d %h %d %h %d %d %d %d %d %h",
					col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
					col[8], col[9], col[10], col[11], col[12], col[13], col[14]);
				if (n != 15) begin
					$display("Could not read line %0d of the test data file", line_no);
					file_errors++;
				end else begin
					// Column 0 repeats the row
					for (k = 0; k < int'(col[0]); k++) begin
						if (cycles >= max_cycles) begin
							timed_out = 1'b1;
							break;
						end
						@(negedge clk);
						drive_row();
						check_en = 1'b1;
						cycles++;
					end
				end
			end
		end
		if (fd != 0)
			$fclose(fd);
		if (timed_out)
			$display("Timed out after %0d cycles before the end of the test data", cycles);

		@(negedge clk);
		check_en = 1'b0;
		query    = '0;
		resolve  = '0;
		repeat (2) @(negedge clk);

		$display("Checks: %0d, value errors: %0d, assertion failures: %0d, %s%0d, timeout: %0d",
			check_count, err_count, dut.props.fail_count, "file errors: ", file_errors,
			timed_out);
		if (err_count == 0 && file_errors == 0 && !timed_out && check_count > 0 &&
		    dut.props.fail_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/bp_checker.sv
`timescale 1ns/1ns
`default_nettype none

module bp_checker import bp_pkg::*; (
	input  wire logic           clk,
	input  wire logic           arst_n,
	input  wire logic           check_en,
	input  wire bp_prediction_t expected,
	input  wire bp_prediction_t prediction,
	output int                  err_count,
	output int                  check_count
);

	initial begin
		err_count   = 0;
		check_count = 0;
	end

	// State updates land after this edge, so the outputs seen here are the settled ones
	always @(posedge clk) begin
		if (arst_n && check_en) begin
			check_count = check_count + 1;
			if (prediction.taken !== expected.taken) begin
				$display("Error at %0t: taken expected %0b got %0b",
					$time, expected.taken, prediction.taken);
				err_count = err_count + 1;
			end
			if (prediction.target_valid !== expected.target_valid) begin
				$display("Error at %0t: target_valid expected %0b got %0b",
					$time, expected.target_valid, prediction.target_valid);
				err_count = err_count + 1;
			end
			if (prediction.target !== expected.target) begin
				$display("Error at %0t: target expected %08h got %08h",
					$time, expected.target, prediction.target);
				err_count = err_count + 1;
			end
		end
	end

endmodule

`default_nettype wire

//--- tests/bp_props.sv
`timescale 1ns/1ns
`default_nettype none

module bp_props import bp_pkg::*; (
	input wire logic           clk,
	input wire logic           arst_n,
	input wire bp_query_t      query,
	input wire bp_prediction_t prediction
);

	int fail_count = 0;

	// Only a return can carry a target
	assert property (@(posedge clk) disable iff (!arst_n)
		prediction.target_valid |-> (query.valid && query.kind == kind_ret))
		else begin
			$error("target_valid high without a return query");
			fail_count++;
		end

	// Quiet output whenever fetch sends nothing
	assert property (@(posedge clk) disable iff (!arst_n)
		!query.valid |-> (!prediction.taken && !prediction.target_valid))
		else begin
			$error("prediction made without a query");
			fail_count++;
		end

	assert property (@(posedge clk) disable iff (!arst_n)
		(query.valid && query.kind == kind_call) |-> prediction.taken)
		else begin
			$error("call query not predicted taken");
			fail_count++;
		end

endmodule

bind branch_predictor bp_props props (
	.clk(clk),
	.arst_n(arst_n),
	.query(query),
	.prediction(prediction)
);

`default_nettype wire

//--- design/branch_predictor.sv
`timescale 1ns/1ns
`default_nettype none

module branch_predictor import bp_pkg::*; (
	input  logic           clk,
	input  logic           arst_n,

	input  bp_query_t      query,
	input  bp_resolve_t    resolve,

	output bp_prediction_t prediction
);

	logic        ghp_guess;
	logic        ghp_train_guess;
	logic        lhp_guess;
	logic        lhp_train_guess;
	logic        lhp_train_en;
	logic        meta_taken;

	logic        ras_push;
	logic        ras_pop;
	logic [31:0] ras_top;
	logic        ras_empty;

	// Local history only learns from beq/bne
	assign lhp_train_en = resolve.valid && resolve.is_eq;

	// Global history
	history_predictor #(
		.hr_width(ghp_hr_width),
		.index_width(ghp_index_width)
	) ghp (
		.clk(clk),
		.arst_n(arst_n),
		.lookup_pc(query.pc),
		.guess(ghp_guess),
		.train_pc(resolve.pc),
		.train_en(resolve.valid),
		.train_taken(resolve.taken),
		.train_guess(ghp_train_guess)
	);

	// Local history
	history_predictor #(
		.hr_width(lhp_hr_width),
		.index_width(lhp_index_width)
	) lhp (
		.clk(clk),
		.arst_n(arst_n),
		.lookup_pc(query.pc),
		.guess(lhp_guess),
		.train_pc(resolve.pc),
		.train_en(lhp_train_en),
		.train_taken(resolve.taken),
		.train_guess(lhp_train_guess)
	);

	meta_predictor meta (
		.clk(clk),
		.arst_n(arst_n),
		.query(query),
		.resolve(resolve),
		.ghp_guess(ghp_guess),
		.lhp_guess(lhp_guess),
		.ghp_train_guess(ghp_train_guess),
		.lhp_train_guess(lhp_train_guess),
		.taken(meta_taken)
	);

	assign ras_push = query.valid && (query.kind == kind_call);
	assign ras_pop  = query.valid && (query.kind == kind_ret);

	return_address_stack ras (
		.clk(clk),
		.arst_n(arst_n),
		.push(ras_push),
		.pop(ras_pop),
		.push_addr(query.pc_next),
		.top_addr(ras_top),
		.empty(ras_empty)
	);

	always_comb begin
		prediction.target_valid = ras_pop && !ras_empty;
		prediction.target       = prediction.target_valid ? ras_top : 32'd0;
		if (!query.valid)
			prediction.taken = 1'b0;
		else if (query.kind == kind_branch)
			prediction.taken = meta_taken;
		else
			prediction.taken = ras_push || ras_pop;
	end

endmodule

`default_nettype wire

//--- design/return_address_stack.sv
`timescale 1ns/1ns
`default_nettype none

module return_address_stack import bp_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,

	input  logic        push,
	input  logic        pop,
	input  logic [31:0] push_addr,

	output logic [31:0] top_addr,
	output logic        empty
);

	logic [31:0]               stack_q [2**ras_addr_width];
	// Next free slot
	logic [ras_addr_width-1:0] ptr_q;
	logic [ras_addr_width:0]   count_q;
	logic [ras_addr_width-1:0] top_ptr;
	logic                      full;

	assign top_ptr  = ptr_q - 1'b1;
	assign top_addr = stack_q[top_ptr];
	assign empty    = (count_q == '0);
	assign full     = (count_q == (ras_addr_width + 1)'(2**ras_addr_width));

	// When full the slot at ptr_q holds the oldest entry
	always_ff @(posedge clk) begin
		if (push)
			stack_q[ptr_q] <= push_addr;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ptr_q   <= '0;
			count_q <= '0;
		end else if (push) begin
			ptr_q <= ptr_q + 1'b1;
			if (!full)
				count_q <= count_q + 1'b1;
		end else if (pop && !empty) begin
			ptr_q   <= top_ptr;
			count_q <= count_q - 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- design/meta_predictor.sv
`timescale 1ns/1ns
`default_nettype none

module meta_predictor import bp_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,

	input  bp_query_t   query,
	input  bp_resolve_t resolve,

	input  logic        ghp_guess,
	input  logic        lhp_guess,
	input  logic        ghp_train_guess,
	input  logic        lhp_train_guess,

	output logic        taken
);

	logic [stat_width-1:0] ghp_stat_q;
	logic [stat_width-1:0] lhp_stat_q;
	logic [stat_width-1:0] sp_stat_q;

	logic ghp_hit;
	logic lhp_hit;
	logic sp_hit;
	logic overflow;

	logic lhp_cand;
	logic pick_ghp;
	logic pick_lhp;

	// Static rule: backward branches taken
	assign ghp_hit = resolve.valid && (ghp_train_guess == resolve.taken);
	assign sp_hit  = resolve.valid && (resolve.imm_neg == resolve.taken);
	// Local table only covers beq/bne
	assign lhp_hit = resolve.valid && resolve.is_eq && (lhp_train_guess == resolve.taken);

	assign overflow = (ghp_hit && (ghp_stat_q == '1)) ||
	                  (lhp_hit && (lhp_stat_q == '1)) ||
	                  (sp_hit  && (sp_stat_q  == '1));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ghp_stat_q <= '0;
			lhp_stat_q <= '0;
			sp_stat_q  <= '0;
		end else if (overflow) begin
			// Keep relative order, make room to keep counting
			ghp_stat_q <= ghp_stat_q >> stat_shift;
			lhp_stat_q <= lhp_stat_q >> stat_shift;
			sp_stat_q  <= sp_stat_q  >> stat_shift;
		end else begin
			ghp_stat_q <= ghp_stat_q + stat_width'(ghp_hit);
			lhp_stat_q <= lhp_stat_q + stat_width'(lhp_hit);
			sp_stat_q  <= sp_stat_q  + stat_width'(sp_hit);
		end
	end

	// Highest counter wins, ties go global, then local, then static
	assign lhp_cand = query.is_eq;
	assign pick_ghp = (ghp_stat_q >= sp_stat_q) && (!lhp_cand || (ghp_stat_q >= lhp_stat_q));
	assign pick_lhp = lhp_cand && (lhp_stat_q >= sp_stat_q);

	always_comb begin
		if (pick_ghp)
			taken = ghp_guess;
		else if (pick_lhp)
			taken = lhp_guess;
		else
			taken = query.imm_neg;
	end

endmodule

`default_nettype wire

//--- design/history_predictor.sv
`timescale 1ns/1ns
`default_nettype none

module history_predictor #(
	parameter int hr_width    = 8,
	parameter int index_width = 8
) (
	input  logic        clk,
	input  logic        arst_n,

	input  logic [31:0] lookup_pc,
	output logic        guess,

	input  logic [31:0] train_pc,
	input  logic        train_en,
	input  logic        train_taken,
	output logic        train_guess
);

	// 2-bit saturating counters, msb is the taken guess
	logic [1:0]             ctr_q [2**index_width];
	logic [hr_width-1:0]    hr_q;

	logic [index_width-1:0] hr_ext;
	logic [index_width-1:0] lookup_idx;
	logic [index_width-1:0] train_idx;
	logic [1:0]             train_ctr;
	logic [1:0]             train_ctr_next;

	// History folded into the word-aligned pc bits
	assign hr_ext     = index_width'(hr_q);
	assign lookup_idx = hr_ext ^ lookup_pc[2 +: index_width];
	assign train_idx  = hr_ext ^ train_pc[2 +: index_width];

	assign guess       = ctr_q[lookup_idx][1];
	assign train_ctr   = ctr_q[train_idx];
	assign train_guess = train_ctr[1];

	always_comb begin
		train_ctr_next = train_ctr;
		if (train_taken) begin
			if (train_ctr != 2'd3)
				train_ctr_next = train_ctr + 2'd1;
		end else begin
			if (train_ctr != 2'd0)
				train_ctr_next = train_ctr - 2'd1;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			// Weakly not-taken
			for (int i = 0; i < 2**index_width; i++)
				ctr_q[i] <= 2'd1;
		end else if (train_en) begin
			ctr_q[train_idx] <= train_ctr_next;
		end
	end

	// Outcome history, newest at bit 0
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			hr_q <= '0;
		else if (train_en)
			hr_q <= {hr_q[hr_width-2:0], train_taken};
	end

endmodule

`default_nettype wire

//--- design/bp_pkg.sv
`default_nettype none

package bp_pkg;

	// Table geometry
	localparam int ghp_hr_width    = 8;
	localparam int ghp_index_width = 8;
	localparam int lhp_hr_width    = 4;
	localparam int lhp_index_width = 6;
	localparam int ras_addr_width  = 3;

	// Meta accuracy counters
	localparam int stat_width = 6;
	localparam int stat_shift = 2;

	typedef enum logic [1:0] {
		kind_none,
		kind_branch,
		kind_call,
		kind_ret
	} br_kind_t;

	typedef struct packed {
		logic        valid;
		br_kind_t    kind;
		logic [31:0] pc;
		logic        is_eq;
		logic        imm_neg;
		logic [31:0] pc_next;
	} bp_query_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic        is_eq;
		logic        imm_neg;
		logic        taken;
	} bp_resolve_t;

	typedef struct packed {
		logic        taken;
		logic        target_valid;
		logic [31:0] target;
	} bp_prediction_t;

endpackage

`default_nettype wire
